// ==== decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Data path and PC width
`define XLEN 32

// Two 32-bit instructions per fetch
`define FETCH_WIDTH 64

`define PC_STEP 4

// Reported when no packet was fetched
`define INVALID_PC {`XLEN{1'b1}}

`endif

// ==== riscv_pkg.sv ====
package riscv_pkg;

  typedef logic [4:0] reg_addr_t;

  // RV32I major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // Operand b straight through, for lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BCU_NONE,
    BCU_EQ,
    BCU_NE,
    BCU_LT,
    BCU_GE,
    BCU_LTU,
    BCU_GEU
  } bcu_op_e;

  typedef enum logic [2:0] {
    LSU_NONE,
    LSU_BYTE,
    LSU_HALF,
    LSU_WORD,
    LSU_BYTE_U,
    LSU_HALF_U
  } lsu_op_e;

endpackage

// ==== pipeline_pkg.sv ====
`include "decode_settings.svh"

package pipeline_pkg;
  import riscv_pkg::*;

  typedef struct packed {
    logic                    valid;  // Single-cycle strobe
    logic [`XLEN-1:0]        pc;
    logic [`FETCH_WIDTH-1:0] data;   // Low word is lane 0
    logic                    pred;
  } fetch_packet_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic ecall;
    logic ebreak;
    logic nop;
    logic valid;
    logic exception;
  } op_flags_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic [31:0]      instr;
    reg_addr_t        waddr;
    reg_addr_t        raddr1;
    reg_addr_t        raddr2;
    logic [`XLEN-1:0] imm;
    op_flags_t        op;
    alu_op_e          alu_op;
    bcu_op_e          bcu_op;
    lsu_op_e          lsu_op;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t instr0;
    decoded_instr_t instr1;
    logic           pred;
  } decode_out_t;

  // Killed lane, also the reset value
  function automatic decoded_instr_t init_instruction();
    decoded_instr_t item;
    item = '0;
    item.pc = `INVALID_PC;
    item.npc = `INVALID_PC;
    return item;
  endfunction

  function automatic decode_out_t init_decode_out();
    decode_out_t item;
    item.instr0 = init_instruction();
    item.instr1 = init_instruction();
    item.pred = 1'b0;
    return item;
  endfunction

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

`include "decode_settings.svh"

module rv_decoder import riscv_pkg::*, pipeline_pkg::*; (
  input  logic [31:0]    instr,
  output decoded_instr_t result
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], {(`XLEN-20){1'b0}}};
  assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  always_comb begin
    result = '0;  // pc and npc are filled by the stage
    result.instr = instr;
    result.waddr = instr[11:7];
    result.raddr1 = instr[19:15];
    result.raddr2 = instr[24:20];
    result.alu_op = ALU_ADD;
    result.bcu_op = BCU_NONE;
    result.lsu_op = LSU_NONE;
    case (opcode)
      OPC_LUI: begin
        result.imm = imm_u;
        result.op.wren = 1'b1;
        result.op.lui = 1'b1;
        result.alu_op = ALU_PASS_B;
        result.op.valid = 1'b1;
      end
      OPC_AUIPC: begin
        result.imm = imm_u;
        result.op.wren = 1'b1;
        result.op.auipc = 1'b1;
        result.op.valid = 1'b1;
      end
      OPC_JAL: begin
        result.imm = imm_j;
        result.op.wren = 1'b1;
        result.op.jal = 1'b1;
        result.op.valid = 1'b1;
      end
      OPC_JALR: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.jalr = 1'b1;
        result.op.valid = (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        result.imm = imm_b;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.branch = 1'b1;
        case (funct3)
          3'b000: result.bcu_op = BCU_EQ;
          3'b001: result.bcu_op = BCU_NE;
          3'b100: result.bcu_op = BCU_LT;
          3'b101: result.bcu_op = BCU_GE;
          3'b110: result.bcu_op = BCU_LTU;
          3'b111: result.bcu_op = BCU_GEU;
          default: result.bcu_op = BCU_NONE;
        endcase
        result.op.valid = (result.bcu_op != BCU_NONE);
      end
      OPC_LOAD: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.load = 1'b1;
        case (funct3)
          3'b000: result.lsu_op = LSU_BYTE;
          3'b001: result.lsu_op = LSU_HALF;
          3'b010: result.lsu_op = LSU_WORD;
          3'b100: result.lsu_op = LSU_BYTE_U;
          3'b101: result.lsu_op = LSU_HALF_U;
          default: result.lsu_op = LSU_NONE;
        endcase
        result.op.valid = (result.lsu_op != LSU_NONE);
      end
      OPC_STORE: begin
        result.imm = imm_s;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.store = 1'b1;
        case (funct3)
          3'b000: result.lsu_op = LSU_BYTE;
          3'b001: result.lsu_op = LSU_HALF;
          3'b010: result.lsu_op = LSU_WORD;
          default: result.lsu_op = LSU_NONE;
        endcase
        result.op.valid = (result.lsu_op != LSU_NONE);
      end
      OPC_OP_IMM: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.alu = 1'b1;
        result.op.nop = (instr == 32'h0000_0013);  // addi x0, x0, 0
        result.op.valid = 1'b1;
        case (funct3)
          3'b000: result.alu_op = ALU_ADD;
          3'b001: begin
            result.alu_op = ALU_SLL;
            result.op.valid = (funct7 == 7'b0000000);
          end
          3'b010: result.alu_op = ALU_SLT;
          3'b011: result.alu_op = ALU_SLTU;
          3'b100: result.alu_op = ALU_XOR;
          3'b101: begin
            result.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
            result.op.valid = ({funct7[6], funct7[4:0]} == 6'b000000);
          end
          3'b110: result.alu_op = ALU_OR;
          default: result.alu_op = ALU_AND;
        endcase
      end
      OPC_OP: begin
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.alu = 1'b1;
        // Bit 30 selects sub and sra, only for funct3 000 and 101
        result.op.valid = (funct7 == 7'b0000000) ||
                          ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000: result.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b001: result.alu_op = ALU_SLL;
          3'b010: result.alu_op = ALU_SLT;
          3'b011: result.alu_op = ALU_SLTU;
          3'b100: result.alu_op = ALU_XOR;
          3'b101: result.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110: result.alu_op = ALU_OR;
          default: result.alu_op = ALU_AND;
        endcase
      end
      OPC_MISC_MEM: begin
        result.op.fence = (funct3 == 3'b000);
        result.op.valid = result.op.fence;
      end
      OPC_SYSTEM: begin
        result.op.ecall = (instr == 32'h0000_0073);
        result.op.ebreak = (instr == 32'h0010_0073);
        result.op.valid = result.op.ecall | result.op.ebreak;  // No CSR support
      end
      default: result.op.valid = 1'b0;
    endcase
  end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

`include "decode_settings.svh"

module decode_stage import pipeline_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  fetch_packet_t fetch,
  input  logic          flush,
  input  logic          halt,
  output decode_out_t   decoded
);

  logic [31:0]    instr0_word;
  logic [31:0]    instr1_word;
  decoded_instr_t dec0;
  decoded_instr_t dec1;
  decode_out_t    next_out;

  assign instr0_word = fetch.valid ? fetch.data[31:0] : '0;
  assign instr1_word = fetch.valid ? fetch.data[`FETCH_WIDTH-1:32] : '0;

  rv_decoder u_decoder0 (
    .instr  (instr0_word),
    .result (dec0)
  );

  rv_decoder u_decoder1 (
    .instr  (instr1_word),
    .result (dec1)
  );

  always_comb begin
    next_out.instr0 = dec0;
    next_out.instr1 = dec1;

    next_out.instr0.pc = fetch.valid ? fetch.pc : `INVALID_PC;
    next_out.instr1.pc = fetch.valid ? fetch.pc + `PC_STEP : `INVALID_PC;
    next_out.instr0.npc = next_out.instr0.pc + `PC_STEP;
    next_out.instr1.npc = next_out.instr1.pc + `PC_STEP;

    next_out.pred = halt ? decoded.pred : fetch.pred;  // Hold pred across halt

    // Unknown encodings travel on as exceptions
    if (fetch.valid) begin
      if (!dec0.op.valid) begin
        next_out.instr0.op.exception = 1'b1;
        next_out.instr0.op.valid = 1'b1;
      end
      if (!dec1.op.valid) begin
        next_out.instr1.op.exception = 1'b1;
        next_out.instr1.op.valid = 1'b1;
      end
    end

    if (!fetch.valid || flush || halt) begin
      next_out.instr0 = init_instruction();
      next_out.instr1 = init_instruction();
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      decoded <= init_decode_out();
    end else begin
      decoded <= next_out;
    end
  end

endmodule

// ==== pair_check.sv ====
`timescale 1ns/1ps

module pair_check import pipeline_pkg::*; (
  input  decode_out_t decoded,
  output logic        dual_issue
);

  logic lanes_ok;
  logic lane0_ctrl;
  logic raw_hazard;
  logic mem_pair;

  assign lanes_ok = decoded.instr0.op.valid && !decoded.instr0.op.exception &&
                    decoded.instr1.op.valid && !decoded.instr1.op.exception;

  // Lane 0 redirects or serializes the pipe
  assign lane0_ctrl = decoded.instr0.op.jal | decoded.instr0.op.jalr |
                      decoded.instr0.op.branch | decoded.instr0.op.fence |
                      decoded.instr0.op.ecall | decoded.instr0.op.ebreak;

  // x0 writes never create a dependency
  assign raw_hazard = decoded.instr0.op.wren && (decoded.instr0.waddr != '0) &&
                      ((decoded.instr1.op.rden1 &&
                        (decoded.instr1.raddr1 == decoded.instr0.waddr)) ||
                       (decoded.instr1.op.rden2 &&
                        (decoded.instr1.raddr2 == decoded.instr0.waddr)));

  assign mem_pair = (decoded.instr0.op.load | decoded.instr0.op.store) &&
                    (decoded.instr1.op.load | decoded.instr1.op.store);  // One LSU port

  assign dual_issue = lanes_ok && !lane0_ctrl && !raw_hazard && !mem_pair;

endmodule

// ==== decode_top.sv ====
`timescale 1ns/1ps

module decode_top import pipeline_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  fetch_packet_t fetch,
  input  logic          flush,   // Trap, mret or mispredict
  input  logic          halt,
  output decode_out_t   decoded,
  output logic          dual_issue
);

  decode_stage u_decode_stage (
    .clock   (clock),
    .reset   (reset),
    .fetch   (fetch),
    .flush   (flush),
    .halt    (halt),
    .decoded (decoded)
  );

  pair_check u_pair_check (
    .decoded    (decoded),
    .dual_issue (dual_issue)
  );

endmodule

// ==== tb_decode_top.sv ====
`timescale 1ns/1ps

`include "decode_settings.svh"

module tb_decode_top import riscv_pkg::*, pipeline_pkg::*; ();

  localparam int RESET_CYCLES  = 5;
  localparam int RESET_TIMEOUT = 50;

  typedef struct packed {
    logic             valid;
    logic             exception;
    logic [3:0]       alu_op;
    logic [`XLEN-1:0] imm;
    logic [4:0]       waddr;
  } lane_expect_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      word0;
    logic [31:0]      word1;
    logic             strobe;
    logic             flush;
    logic             halt;
    logic             pred;
    lane_expect_t     lane0;
    lane_expect_t     lane1;
    logic [`XLEN-1:0] exp_pc;    // Lane 1 follows one step later
    logic             exp_dual;
    logic             exp_pred;
  } test_row_t;

  logic          clock;
  logic          reset;
  fetch_packet_t fetch;
  logic          flush;
  logic          halt;
  decode_out_t   decoded;
  logic          dual_issue;

  test_row_t rows[$];
  string     row_names[$];
  int        field_errors;
  int        tests_passed;
  int        tests_failed;
  int        wait_cycles;

  decode_top UUT (
    .clock      (clock),
    .reset      (reset),
    .fetch      (fetch),
    .flush      (flush),
    .halt       (halt),
    .decoded    (decoded),
    .dual_issue (dual_issue)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b1;
  end

  function automatic lane_expect_t expect_lane(input logic valid, input logic exception,
                                               input logic [3:0] alu_op,
                                               input logic [31:0] imm, input logic [4:0] waddr);
    lane_expect_t lane;
    lane.valid = valid;
    lane.exception = exception;
    lane.alu_op = alu_op;
    lane.imm = imm;
    lane.waddr = waddr;
    return lane;
  endfunction

  task automatic add_test(input string name, input logic [31:0] pc, input logic [31:0] word0,
                          input logic [31:0] word1, input logic [3:0] controls,
                          input lane_expect_t lane0, input lane_expect_t lane1,
                          input logic [31:0] exp_pc, input logic exp_dual,
                          input logic exp_pred);
    test_row_t row;
    row.pc = pc;
    row.word0 = word0;
    row.word1 = word1;
    {row.strobe, row.flush, row.halt, row.pred} = controls;
    row.lane0 = lane0;
    row.lane1 = lane1;
    row.exp_pc = exp_pc;
    row.exp_dual = exp_dual;
    row.exp_pred = exp_pred;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  task automatic build_table();
    lane_expect_t killed;
    lane_expect_t addi_x5;
    lane_expect_t lui_x6;
    lane_expect_t addi_x7;
    killed  = expect_lane(1'b0, 1'b0, ALU_ADD, 32'h0000_0000, 5'd0);
    addi_x5 = expect_lane(1'b1, 1'b0, ALU_ADD, 32'hFFFF_FFFD, 5'd5);
    lui_x6  = expect_lane(1'b1, 1'b0, ALU_PASS_B, 32'h1234_5000, 5'd6);
    addi_x7 = expect_lane(1'b1, 1'b0, ALU_ADD, 32'h0000_0064, 5'd7);
    // Controls are strobe, flush, halt, pred
    add_test("idle_after_reset", 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 4'b0000,
             killed, killed, `INVALID_PC, 1'b0, 1'b0);
    add_test("addi_lui", 32'h0000_1000, 32'hFFD0_8293, 32'h1234_5337, 4'b1000,
             addi_x5, lui_x6, 32'h0000_1000, 1'b1, 1'b0);
    add_test("branch_store", 32'h0000_2000, 32'hFE20_8CE3, 32'hFE31_2A23, 4'b1000,
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'hFFFF_FFF8, 5'd25),
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'hFFFF_FFF4, 5'd20),
             32'h0000_2000, 1'b0, 1'b0);
    add_test("jal_addi", 32'h0000_3000, 32'h8030_10EF, 32'h0640_0393, 4'b1000,
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'hFFF0_1802, 5'd1), addi_x7,
             32'h0000_3000, 1'b0, 1'b0);
    add_test("illegal_zero", 32'h0000_4000, 32'h0000_0000, 32'h0640_0393, 4'b1000,
             expect_lane(1'b1, 1'b1, ALU_ADD, 32'h0000_0000, 5'd0), addi_x7,
             32'h0000_4000, 1'b0, 1'b0);
    add_test("illegal_opcode", 32'h0000_4008, 32'h0640_0393, 32'hFFFF_FFFF, 4'b1000,
             addi_x7, expect_lane(1'b1, 1'b1, ALU_ADD, 32'h0000_0000, 5'd31),
             32'h0000_4008, 1'b0, 1'b0);
    add_test("raw_hazard", 32'h0000_5000, 32'hFFD0_8293, 32'h0022_8333, 4'b1000,
             addi_x5, expect_lane(1'b1, 1'b0, ALU_ADD, 32'h0000_0000, 5'd6),
             32'h0000_5000, 1'b0, 1'b0);
    add_test("independent_alu", 32'h0000_5008, 32'hFFD0_8293, 32'h4021_8333, 4'b1000,
             addi_x5, expect_lane(1'b1, 1'b0, ALU_SUB, 32'h0000_0000, 5'd6),
             32'h0000_5008, 1'b1, 1'b0);
    add_test("x0_no_hazard", 32'h0000_5010, 32'h0000_0013, 32'h0000_4333, 4'b1000,
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'h0000_0000, 5'd0),
             expect_lane(1'b1, 1'b0, ALU_XOR, 32'h0000_0000, 5'd6),
             32'h0000_5010, 1'b1, 1'b0);
    add_test("load_pair", 32'h0000_5018, 32'h0080_A283, 32'hFFF1_4303, 4'b1001,
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'h0000_0008, 5'd5),
             expect_lane(1'b1, 1'b0, ALU_ADD, 32'hFFFF_FFFF, 5'd6),
             32'h0000_5018, 1'b0, 1'b1);
    add_test("halt_hold", 32'h0000_5020, 32'hFFD0_8293, 32'h1234_5337, 4'b1010,
             killed, killed, `INVALID_PC, 1'b0, 1'b1);  // Pred kept from load_pair
    add_test("flush_kill", 32'h0000_5028, 32'hFFD0_8293, 32'h1234_5337, 4'b1101,
             killed, killed, `INVALID_PC, 1'b0, 1'b1);
    add_test("resume", 32'h0000_6000, 32'hFFD0_8293, 32'h1234_5337, 4'b1000,
             addi_x5, lui_x6, 32'h0000_6000, 1'b1, 1'b0);
  endtask

  task automatic check_field(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s %s expected 0x%08h actual 0x%08h", test_name, field, expected, actual);
      field_errors++;
    end
  endtask

  task automatic compare_lane(input string test_name, input string lane_name,
                              input lane_expect_t expected, input logic [31:0] exp_pc,
                              input decoded_instr_t actual);
    logic [31:0] exp_npc;
    exp_npc = (exp_pc == `INVALID_PC) ? `INVALID_PC : exp_pc + `PC_STEP;
    check_field(test_name, {lane_name, ".valid"}, 32'(expected.valid), 32'(actual.op.valid));
    check_field(test_name, {lane_name, ".exception"}, 32'(expected.exception),
                32'(actual.op.exception));
    check_field(test_name, {lane_name, ".alu_op"}, 32'(expected.alu_op), 32'(actual.alu_op));
    check_field(test_name, {lane_name, ".imm"}, expected.imm, actual.imm);
    check_field(test_name, {lane_name, ".waddr"}, 32'(expected.waddr), 32'(actual.waddr));
    check_field(test_name, {lane_name, ".pc"}, exp_pc, actual.pc);
    check_field(test_name, {lane_name, ".npc"}, exp_npc, actual.npc);
  endtask

  task automatic run_row(input int index);
    test_row_t   row;
    logic [31:0] exp_pc1;
    row = rows[index];
    exp_pc1 = (row.exp_pc == `INVALID_PC) ? `INVALID_PC : row.exp_pc + `PC_STEP;
    field_errors = 0;
    @(posedge clock);
    fetch.valid <= row.strobe;
    fetch.pc <= row.pc;
    fetch.data <= {row.word1, row.word0};
    fetch.pred <= row.pred;
    flush <= row.flush;
    halt <= row.halt;
    @(posedge clock);  // Packet is registered here
    fetch.valid <= 1'b0;
    flush <= 1'b0;
    halt <= 1'b0;
    @(negedge clock);
    compare_lane(row_names[index], "lane0", row.lane0, row.exp_pc, decoded.instr0);
    compare_lane(row_names[index], "lane1", row.lane1, exp_pc1, decoded.instr1);
    check_field(row_names[index], "dual_issue", 32'(row.exp_dual), 32'(dual_issue));
    check_field(row_names[index], "pred", 32'(row.exp_pred), 32'(decoded.pred));
    if (field_errors == 0) begin
      $display("PASS %s", row_names[index]);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d mismatches", row_names[index], field_errors);
      tests_failed++;
    end
  endtask

  initial begin
    fetch <= '0;
    flush <= 1'b0;
    halt <= 1'b0;
    field_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait_cycles = 0;
    build_table();
    while (reset !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
      @(posedge clock);
      wait_cycles++;
    end
    if (reset !== 1'b1) begin
      $display("Reset was still active after %0d cycles", RESET_TIMEOUT);
      $display("Verification failed");
      $finish;
    end else begin
      for (int i = 0; i < rows.size(); i++) begin
        run_row(i);
      end
      $display("Tests run %0d, passed %0d, failed %0d", rows.size(), tests_passed,
               tests_failed);
      if (tests_failed == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+.
riscv_pkg.sv
pipeline_pkg.sv
rv_decoder.sv
decode_stage.sv
pair_check.sv
decode_top.sv
tb_decode_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_decode_top -f files.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
